// File: hdl/roce_resp_config.svh
`ifndef ROCE_RESP_CONFIG_SVH
`define ROCE_RESP_CONFIG_SVH

// stream geometry in bytes
`define AXIS_BYTES        64
`define HDR_BYTES         58
`define RD_PAYLOAD_BYTES  256

`define NUM_RD_PKT        4
`define NUM_WR_PKT        4
`define IPG_CYCLES        16   // idle cycles after each packet

// WQE field offsets with the msb byte first
`define WQE_PSN_BYTE      51
`define WQE_QP_BYTE       47

`define IP_LEN_RD         16'h0130
`define IP_LEN_ACK        16'h0030
`define OPC_RD_RESP       8'h10
`define OPC_ACK           8'h11

// fixed header fields
`define ETH_TYPE_IPV4     16'h0800
`define IP_VER_IHL        8'h45
`define IP_TOS            8'hb8
`define IP_ID             16'h5555
`define IP_FLAGS          16'h4000
`define IP_TTL            8'hba
`define IP_PROTO_UDP      8'h11
`define UDP_SRC_PORT      16'h6851
`define UDP_DST_PORT      16'h12b7
`define BTH_PKEY          16'h666f

`endif

// File: hdl/roce_resp_pkg.sv
`default_nettype none
`include "roce_resp_config.svh"

package roce_resp_pkg;

  typedef enum logic {
    RD_RESP = 1'b0,
    ACK     = 1'b1
  } resp_kind_e;

  typedef logic [23:0] qp_num_t;
  typedef logic [23:0] psn_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;

  typedef logic [`AXIS_BYTES*8-1:0] axis_data_t;
  typedef logic [`AXIS_BYTES-1:0]   axis_keep_t;
  typedef logic [`HDR_BYTES*8-1:0]  roce_hdr_t;  // byte n at [8n+7:8n]

  // sum of the nine header words without the checksum word
  // first word sits in the top bits
  function automatic logic [15:0] ipv4_chksum(input logic [143:0] words);
    logic [19:0] sum;
    sum = '0;
    for (int i = 0; i < 9; i++) begin
      sum = sum + 20'(words[i*16 +: 16]);
    end
    // two folds catch the carry out of the first one
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    return ~sum[15:0];
  endfunction

endpackage

`default_nettype wire

// File: hdl/tx_job_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tx_job_if;
  import roce_resp_pkg::*;

  logic       job_valid;  // one-cycle job strobe
  resp_kind_e job_kind;
  roce_hdr_t  job_hdr;
  logic [7:0] job_fill;   // payload byte value
  logic       job_done;   // packet out and gap elapsed

  // header builder side
  modport source (
    output job_valid,
    output job_kind,
    output job_hdr,
    output job_fill,
    input  job_done
  );

  // serializer side
  modport sink (
    input  job_valid,
    input  job_kind,
    input  job_hdr,
    input  job_fill,
    output job_done
  );

endinterface

`default_nettype wire

// File: hdl/wqe_req_capture.sv
`timescale 1ns/1ns
`default_nettype none
`include "roce_resp_config.svh"

module wqe_req_capture (
  input  wire                            core_clk,
  input  wire                            core_aresetn,
  input  wire roce_resp_pkg::axis_data_t wqe_tdata_i,
  input  wire                            wqe_tvalid_i,
  input  wire                            wqe_tlast_i,
  output logic                           req_valid_o,
  output roce_resp_pkg::qp_num_t         req_qp_o,
  output roce_resp_pkg::psn_t            req_psn_o
);
  import roce_resp_pkg::*;

  logic    first_beat;
  qp_num_t wqe_qp;
  psn_t    wqe_psn;

  // big endian fields inside the beat
  assign wqe_qp  = {wqe_tdata_i[`WQE_QP_BYTE*8 +: 8],
                    wqe_tdata_i[(`WQE_QP_BYTE+1)*8 +: 8],
                    wqe_tdata_i[(`WQE_QP_BYTE+2)*8 +: 8]};
  assign wqe_psn = {wqe_tdata_i[`WQE_PSN_BYTE*8 +: 8],
                    wqe_tdata_i[(`WQE_PSN_BYTE+1)*8 +: 8],
                    wqe_tdata_i[(`WQE_PSN_BYTE+2)*8 +: 8]};

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      first_beat  <= 1'b1;
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= wqe_tvalid_i & wqe_tlast_i;
      if (wqe_tvalid_i) begin
        first_beat <= wqe_tlast_i;  // rearm after last beat
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (wqe_tvalid_i && first_beat) begin
      req_qp_o  <= wqe_qp;
      req_psn_o <= wqe_psn;
    end
  end

endmodule

`default_nettype wire

// File: hdl/resp_seq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "roce_resp_config.svh"

module resp_seq_ctrl (
  input  wire                       core_clk,
  input  wire                       core_aresetn,
  input  wire                       conf_done_i,
  input  wire                       job_done_i,
  output roce_resp_pkg::resp_kind_e kind_o,
  output logic [3:0]                pkt_idx_o,
  output logic                      post_rd_wqe_o,
  output logic                      post_wr_wqe_o,
  output logic                      rd_done_o,
  output logic                      wr_done_o
);
  import roce_resp_pkg::*;

  typedef enum logic [2:0] {
    S_RD_IDLE,
    S_RD_POST,
    S_RD_WAIT,
    S_WR_IDLE,
    S_WR_POST,
    S_WR_WAIT,
    S_DONE
  } seq_state_e;

  localparam logic [3:0] LAST_RD = 4'(`NUM_RD_PKT - 1);
  localparam logic [3:0] LAST_WR = 4'(`NUM_WR_PKT - 1);

  seq_state_e state;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state     <= S_RD_IDLE;
      pkt_idx_o <= '0;
      rd_done_o <= 1'b0;
      wr_done_o <= 1'b0;
    end else begin
      case (state)
        S_RD_IDLE: if (conf_done_i) state <= S_RD_POST;
        S_RD_POST: state <= S_RD_WAIT;
        S_RD_WAIT: begin
          if (job_done_i) begin
            if (pkt_idx_o == LAST_RD) begin
              pkt_idx_o <= '0;
              rd_done_o <= 1'b1;
              state     <= S_WR_IDLE;  // write phase starts here
            end else begin
              pkt_idx_o <= pkt_idx_o + 4'd1;
              state     <= S_RD_POST;
            end
          end
        end
        S_WR_IDLE: if (conf_done_i) state <= S_WR_POST;
        S_WR_POST: state <= S_WR_WAIT;
        S_WR_WAIT: begin
          if (job_done_i) begin
            if (pkt_idx_o == LAST_WR) begin
              wr_done_o <= 1'b1;
              state     <= S_DONE;
            end else begin
              pkt_idx_o <= pkt_idx_o + 4'd1;
              state     <= S_WR_POST;
            end
          end
        end
        S_DONE: state <= S_DONE;  // both flags held
        default: state <= S_RD_IDLE;
      endcase
    end
  end

  // one cycle per post state
  assign post_rd_wqe_o = (state == S_RD_POST);
  assign post_wr_wqe_o = (state == S_WR_POST);

  assign kind_o = (state == S_RD_IDLE || state == S_RD_POST || state == S_RD_WAIT) ?
                  RD_RESP : ACK;

endmodule

`default_nettype wire

// File: hdl/roce_hdr_builder.sv
`timescale 1ns/1ns
`default_nettype none
`include "roce_resp_config.svh"

module roce_hdr_builder (
  input  wire                             core_clk,
  input  wire                             core_aresetn,
  input  wire                             req_valid_i,
  input  wire roce_resp_pkg::qp_num_t     req_qp_i,
  input  wire roce_resp_pkg::psn_t        req_psn_i,
  input  wire roce_resp_pkg::resp_kind_e  kind_i,
  input  wire [3:0]                       pkt_idx_i,
  input  wire roce_resp_pkg::mac_addr_t   src_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  src_ip_i,
  input  wire roce_resp_pkg::mac_addr_t   qp3_dst_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  qp3_dst_ip_i,
  input  wire roce_resp_pkg::mac_addr_t   qp4_dst_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  qp4_dst_ip_i,
  tx_job_if.source                        job
);
  import roce_resp_pkg::*;

  mac_addr_t               dst_mac;
  ipv4_addr_t              dst_ip;
  logic [15:0]             ip_len;
  logic [15:0]             udp_len;
  logic [7:0]              opcode;
  logic [15:0]             ip_csum;
  logic [`HDR_BYTES*8-1:0] hdr_wire;   // wire order with byte 0 on top
  roce_hdr_t               hdr_lanes;

  // anything but QP4 falls back to the QP3 entry
  assign dst_mac = (req_qp_i == 24'd4) ? qp4_dst_mac_i : qp3_dst_mac_i;
  assign dst_ip  = (req_qp_i == 24'd4) ? qp4_dst_ip_i : qp3_dst_ip_i;

  assign ip_len  = (kind_i == RD_RESP) ? `IP_LEN_RD : `IP_LEN_ACK;
  assign udp_len = ip_len - 16'd20;
  assign opcode  = (kind_i == RD_RESP) ? `OPC_RD_RESP : `OPC_ACK;

  assign ip_csum = ipv4_chksum({`IP_VER_IHL, `IP_TOS, ip_len, `IP_ID, `IP_FLAGS,
                                `IP_TTL, `IP_PROTO_UDP, dst_ip, src_ip_i});

  assign hdr_wire = {
    // ethernet
    dst_mac, src_mac_i, `ETH_TYPE_IPV4,
    // ipv4
    `IP_VER_IHL, `IP_TOS, ip_len, `IP_ID, `IP_FLAGS, `IP_TTL, `IP_PROTO_UDP,
    ip_csum, dst_ip, src_ip_i,
    // udp with a zero checksum
    `UDP_SRC_PORT, `UDP_DST_PORT, udp_len, 16'h0000,
    // bth
    opcode, 8'h00, `BTH_PKEY, 8'h00, req_qp_i, 8'h00, req_psn_i,
    32'h0000_0000  // aeth
  };

  // byte 0 goes to lane 0
  always_comb begin
    for (int i = 0; i < `HDR_BYTES; i++) begin
      hdr_lanes[i*8 +: 8] = hdr_wire[(`HDR_BYTES-1-i)*8 +: 8];
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      job.job_valid <= 1'b0;
    end else begin
      job.job_valid <= req_valid_i;
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_valid_i) begin
      job.job_kind <= kind_i;
      job.job_hdr  <= hdr_lanes;
      job.job_fill <= {4'h1, pkt_idx_i + 4'd1};
    end
  end

endmodule

`default_nettype wire

// File: hdl/axis_beat_serializer.sv
`timescale 1ns/1ns
`default_nettype none
`include "roce_resp_config.svh"

module axis_beat_serializer (
  input  wire                        core_clk,
  input  wire                        core_aresetn,
  input  wire                        tx_tready_i,
  tx_job_if.sink                     job,
  output roce_resp_pkg::axis_data_t  tx_tdata_o,
  output roce_resp_pkg::axis_keep_t  tx_tkeep_o,
  output logic                       tx_tvalid_o,
  output logic                       tx_tlast_o
);
  import roce_resp_pkg::*;

  localparam logic [8:0] RD_BYTES   = 9'(`HDR_BYTES + `RD_PAYLOAD_BYTES);
  localparam logic [8:0] ACK_BYTES  = 9'(`HDR_BYTES);
  localparam logic [8:0] BEAT_BYTES = 9'(`AXIS_BYTES);
  localparam logic [7:0] GAP_LAST   = 8'(`IPG_CYCLES - 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SEND,
    S_GAP
  } ser_state_e;

  ser_state_e state;
  logic [7:0] fill_q;
  logic [8:0] rem_q;      // bytes left after the beat on the bus
  logic [7:0] gap_cnt;

  logic       first_sel;
  logic       load_beat;
  logic [7:0] src_fill;
  logic [8:0] src_rem;
  axis_data_t hdr_pad;
  axis_data_t next_data;
  axis_keep_t next_keep;

  assign first_sel = (state == S_IDLE);
  assign src_fill  = first_sel ? job.job_fill : fill_q;
  assign src_rem   = !first_sel ? rem_q :
                     (job.job_kind == RD_RESP) ? RD_BYTES : ACK_BYTES;
  assign hdr_pad   = axis_data_t'(job.job_hdr);

  // new beat on job start or on accept of a non-last beat
  assign load_beat = (first_sel && job.job_valid) ||
                     (state == S_SEND && tx_tready_i && !tx_tlast_o);

  always_comb begin
    for (int l = 0; l < `AXIS_BYTES; l++) begin
      next_keep[l] = (9'(l) < src_rem);
      if (!next_keep[l]) begin
        next_data[l*8 +: 8] = 8'h00;
      end else if (first_sel && l < `HDR_BYTES) begin
        next_data[l*8 +: 8] = hdr_pad[l*8 +: 8];  // header only in beat 0
      end else begin
        next_data[l*8 +: 8] = src_fill;
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state        <= S_IDLE;
      rem_q        <= '0;
      gap_cnt      <= '0;
      tx_tvalid_o  <= 1'b0;
      tx_tlast_o   <= 1'b0;
      job.job_done <= 1'b0;
    end else begin
      job.job_done <= 1'b0;
      if (load_beat) begin
        tx_tvalid_o <= 1'b1;
        tx_tlast_o  <= (src_rem <= BEAT_BYTES);
        rem_q       <= (src_rem > BEAT_BYTES) ? src_rem - BEAT_BYTES : 9'd0;
      end
      case (state)
        S_IDLE: if (job.job_valid) state <= S_SEND;
        S_SEND: begin
          if (tx_tready_i && tx_tlast_o) begin
            tx_tvalid_o <= 1'b0;
            tx_tlast_o  <= 1'b0;
            gap_cnt     <= '0;
            state       <= S_GAP;
          end
        end
        S_GAP: begin
          if (gap_cnt == GAP_LAST) begin
            job.job_done <= 1'b1;
            state        <= S_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 8'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // beat payload only moves on load, so it holds under back-pressure
  always_ff @(posedge core_clk) begin
    if (load_beat) begin
      tx_tdata_o <= next_data;
      tx_tkeep_o <= next_keep;
    end
    if (first_sel && job.job_valid) begin
      fill_q <= job.job_fill;
    end
  end

endmodule

`default_nettype wire

// File: hdl/roce_resp_gen_top.sv
`timescale 1ns/1ns
`default_nettype none

module roce_resp_gen_top (
  input  wire                             core_clk,
  input  wire                             core_aresetn,
  input  wire                             conf_done_i,
  input  wire roce_resp_pkg::mac_addr_t   src_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  src_ip_i,
  input  wire roce_resp_pkg::mac_addr_t   qp3_dst_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  qp3_dst_ip_i,
  input  wire roce_resp_pkg::mac_addr_t   qp4_dst_mac_i,
  input  wire roce_resp_pkg::ipv4_addr_t  qp4_dst_ip_i,
  input  wire roce_resp_pkg::axis_data_t  wqe_tdata_i,
  input  wire                             wqe_tvalid_i,
  input  wire                             wqe_tlast_i,
  input  wire                             tx_tready_i,
  output wire roce_resp_pkg::axis_data_t  tx_tdata_o,
  output wire roce_resp_pkg::axis_keep_t  tx_tkeep_o,
  output wire                             tx_tvalid_o,
  output wire                             tx_tlast_o,
  output wire                             post_rd_wqe_o,
  output wire                             post_wr_wqe_o,
  output wire                             rd_done_o,
  output wire                             wr_done_o
);
  import roce_resp_pkg::*;

  logic       req_valid;
  qp_num_t    req_qp;
  psn_t       req_psn;
  resp_kind_e seq_kind;
  logic [3:0] seq_pkt_idx;

  tx_job_if job_bus ();

  wqe_req_capture u_capture (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .wqe_tdata_i  (wqe_tdata_i),
    .wqe_tvalid_i (wqe_tvalid_i),
    .wqe_tlast_i  (wqe_tlast_i),
    .req_valid_o  (req_valid),
    .req_qp_o     (req_qp),
    .req_psn_o    (req_psn)
  );

  resp_seq_ctrl u_seq (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .conf_done_i   (conf_done_i),
    .job_done_i    (job_bus.job_done),
    .kind_o        (seq_kind),
    .pkt_idx_o     (seq_pkt_idx),
    .post_rd_wqe_o (post_rd_wqe_o),
    .post_wr_wqe_o (post_wr_wqe_o),
    .rd_done_o     (rd_done_o),
    .wr_done_o     (wr_done_o)
  );

  roce_hdr_builder u_hdr (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .req_valid_i   (req_valid),
    .req_qp_i      (req_qp),
    .req_psn_i     (req_psn),
    .kind_i        (seq_kind),
    .pkt_idx_i     (seq_pkt_idx),
    .src_mac_i     (src_mac_i),
    .src_ip_i      (src_ip_i),
    .qp3_dst_mac_i (qp3_dst_mac_i),
    .qp3_dst_ip_i  (qp3_dst_ip_i),
    .qp4_dst_mac_i (qp4_dst_mac_i),
    .qp4_dst_ip_i  (qp4_dst_ip_i),
    .job           (job_bus.source)
  );

  axis_beat_serializer u_ser (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .tx_tready_i  (tx_tready_i),
    .job          (job_bus.sink),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o)
  );

endmodule

`default_nettype wire

// File: verif/roce_resp_gen_chk.sv
`timescale 1ns/1ns
`default_nettype none

module roce_resp_gen_chk (
  input wire                            core_clk,
  input wire                            core_aresetn,
  input wire                            conf_done_i,
  input wire                            tx_tready_i,
  input wire roce_resp_pkg::axis_data_t tx_tdata_o,
  input wire roce_resp_pkg::axis_keep_t tx_tkeep_o,
  input wire                            tx_tvalid_o,
  input wire                            tx_tlast_o,
  input wire                            post_rd_wqe_o,
  input wire                            post_wr_wqe_o,
  input wire                            rd_done_o,
  input wire                            wr_done_o
);
  int unsigned assert_fails = 0;

  // beat must hold while the sink stalls
  hold_under_stall: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_tvalid_o && !tx_tready_i |=>
      tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tkeep_o) && $stable(tx_tlast_o))
    else begin
      assert_fails++;
      $error("tx beat changed while tready was low");
    end

  post_rd_single: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_rd_wqe_o |=> !post_rd_wqe_o)
    else begin
      assert_fails++;
      $error("post_rd_wqe_o high for more than one cycle");
    end

  post_wr_single: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_wr_wqe_o |=> !post_wr_wqe_o)
    else begin
      assert_fails++;
      $error("post_wr_wqe_o high for more than one cycle");
    end

  quiet_before_conf: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    !conf_done_i |-> !(post_rd_wqe_o || post_wr_wqe_o || tx_tvalid_o))
    else begin
      assert_fails++;
      $error("activity before conf_done_i");
    end

  rd_done_held: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    rd_done_o |=> rd_done_o)
    else begin
      assert_fails++;
      $error("rd_done_o dropped");
    end

  wr_done_held: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    wr_done_o |=> wr_done_o && rd_done_o)
    else begin
      assert_fails++;
      $error("wr_done_o dropped or high without rd_done_o");
    end

endmodule

`default_nettype wire

// File: verif/tb_roce_resp_gen.sv
`timescale 1ns/1ns
`default_nettype none
`include "roce_resp_config.svh"

module tb_roce_resp_gen;
  import roce_resp_pkg::*;

  localparam int NUM_RD     = `NUM_RD_PKT;
  localparam int NUM_PKT    = `NUM_RD_PKT + `NUM_WR_PKT;
  localparam int STIM_WORDS = 6 + 4 * NUM_PKT;
  localparam int TIMEOUT    = 2000;  // cycles per wait

  logic       core_clk;
  logic       core_aresetn;
  logic       conf_done_i;
  mac_addr_t  src_mac_i;
  ipv4_addr_t src_ip_i;
  mac_addr_t  qp3_dst_mac_i;
  ipv4_addr_t qp3_dst_ip_i;
  mac_addr_t  qp4_dst_mac_i;
  ipv4_addr_t qp4_dst_ip_i;
  axis_data_t wqe_tdata_i;
  logic       wqe_tvalid_i;
  logic       wqe_tlast_i;
  logic       tx_tready_i;
  axis_data_t tx_tdata_o;
  axis_keep_t tx_tkeep_o;
  logic       tx_tvalid_o;
  logic       tx_tlast_o;
  logic       post_rd_wqe_o;
  logic       post_wr_wqe_o;
  logic       rd_done_o;
  logic       wr_done_o;

  logic [47:0] stim [STIM_WORDS];
  integer      seed = 32'hb12530b1;
  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          rd_posts = 0;
  int          wr_posts = 0;
  axis_data_t  beat_data [8];
  axis_keep_t  beat_keep [8];
  logic        beat_last [8];

  roce_resp_gen_top DUT (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .conf_done_i   (conf_done_i),
    .src_mac_i     (src_mac_i),
    .src_ip_i      (src_ip_i),
    .qp3_dst_mac_i (qp3_dst_mac_i),
    .qp3_dst_ip_i  (qp3_dst_ip_i),
    .qp4_dst_mac_i (qp4_dst_mac_i),
    .qp4_dst_ip_i  (qp4_dst_ip_i),
    .wqe_tdata_i   (wqe_tdata_i),
    .wqe_tvalid_i  (wqe_tvalid_i),
    .wqe_tlast_i   (wqe_tlast_i),
    .tx_tready_i   (tx_tready_i),
    .tx_tdata_o    (tx_tdata_o),
    .tx_tkeep_o    (tx_tkeep_o),
    .tx_tvalid_o   (tx_tvalid_o),
    .tx_tlast_o    (tx_tlast_o),
    .post_rd_wqe_o (post_rd_wqe_o),
    .post_wr_wqe_o (post_wr_wqe_o),
    .rd_done_o     (rd_done_o),
    .wr_done_o     (wr_done_o)
  );

  bind roce_resp_gen_top roce_resp_gen_chk u_chk (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .conf_done_i   (conf_done_i),
    .tx_tready_i   (tx_tready_i),
    .tx_tdata_o    (tx_tdata_o),
    .tx_tkeep_o    (tx_tkeep_o),
    .tx_tvalid_o   (tx_tvalid_o),
    .tx_tlast_o    (tx_tlast_o),
    .post_rd_wqe_o (post_rd_wqe_o),
    .post_wr_wqe_o (post_wr_wqe_o),
    .rd_done_o     (rd_done_o),
    .wr_done_o     (wr_done_o)
  );

  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_hdr(input string name, input roce_hdr_t exp, input roce_hdr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_beat(input string name, input axis_data_t exp_d, input axis_keep_t exp_k,
                            input axis_data_t act_d, input axis_keep_t act_k);
    if (act_d !== exp_d || act_k !== exp_k) begin
      $display("CHECK FAILED %s: expected keep %h data %h, actual keep %h data %h",
               name, exp_k, exp_d, act_k, act_d);
      err_cnt++;
    end
  endtask

  task automatic finish_run;
    int asrt;
    asrt = DUT.u_chk.assert_fails;
    $display("error counts: %0d compare, %0d timeout, %0d assertion",
             err_cnt, timeout_cnt, asrt);
    if (err_cnt + timeout_cnt + asrt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timeout_cnt++;
  endtask

  // msb byte at the lowest offset
  function automatic roce_hdr_t put_field(input roce_hdr_t h, input int off, input int n,
                                          input logic [47:0] val);
    roce_hdr_t r;
    r = h;
    for (int i = 0; i < n; i++) begin
      r[(off + i)*8 +: 8] = val[(n - 1 - i)*8 +: 8];
    end
    return r;
  endfunction

  function automatic roce_hdr_t expected_hdr(input resp_kind_e kind, input qp_num_t qp,
                                             input psn_t psn, input logic [15:0] csum);
    roce_hdr_t   h;
    logic [15:0] len;
    logic        use_qp4;
    use_qp4 = (qp == 24'd4);
    len = (kind == RD_RESP) ? `IP_LEN_RD : `IP_LEN_ACK;
    h = '0;  // reserved bytes and aeth stay zero
    h = put_field(h, 0, 6, use_qp4 ? qp4_dst_mac_i : qp3_dst_mac_i);
    h = put_field(h, 6, 6, src_mac_i);
    h = put_field(h, 12, 2, 48'(`ETH_TYPE_IPV4));
    h = put_field(h, 14, 2, 48'({`IP_VER_IHL, `IP_TOS}));
    h = put_field(h, 16, 2, 48'(len));
    h = put_field(h, 18, 2, 48'(`IP_ID));
    h = put_field(h, 20, 2, 48'(`IP_FLAGS));
    h = put_field(h, 22, 2, 48'({`IP_TTL, `IP_PROTO_UDP}));
    h = put_field(h, 24, 2, 48'(csum));
    h = put_field(h, 26, 4, 48'(use_qp4 ? qp4_dst_ip_i : qp3_dst_ip_i));
    h = put_field(h, 30, 4, 48'(src_ip_i));
    h = put_field(h, 34, 2, 48'(`UDP_SRC_PORT));
    h = put_field(h, 36, 2, 48'(`UDP_DST_PORT));
    h = put_field(h, 38, 2, 48'(len - 16'd20));
    h = put_field(h, 42, 1, 48'((kind == RD_RESP) ? `OPC_RD_RESP : `OPC_ACK));
    h = put_field(h, 44, 2, 48'(`BTH_PKEY));
    h = put_field(h, 47, 3, 48'(qp));
    h = put_field(h, 51, 3, 48'(psn));
    return h;
  endfunction

  function automatic int pkt_bytes(input resp_kind_e kind);
    return (kind == RD_RESP) ? `HDR_BYTES + `RD_PAYLOAD_BYTES : `HDR_BYTES;
  endfunction

  function automatic axis_data_t wqe_beat(input qp_num_t qp, input psn_t psn,
                                          input logic [7:0] base);
    axis_data_t d;
    for (int l = 0; l < `AXIS_BYTES; l++) begin
      d[l*8 +: 8] = base ^ 8'(l);  // background noise
    end
    for (int i = 0; i < 3; i++) begin
      d[(`WQE_QP_BYTE + i)*8 +: 8]  = qp[(2 - i)*8 +: 8];
      d[(`WQE_PSN_BYTE + i)*8 +: 8] = psn[(2 - i)*8 +: 8];
    end
    return d;
  endfunction

  task automatic wait_post(output logic is_rd);
    int n;
    n = 0;
    @(negedge core_clk);
    while (!post_rd_wqe_o && !post_wr_wqe_o && n < TIMEOUT) begin
      n++;
      @(negedge core_clk);
    end
    if (!post_rd_wqe_o && !post_wr_wqe_o) begin
      timed_out("a post strobe");
    end
    is_rd = post_rd_wqe_o;
  endtask

  task automatic wait_done(input bit wr_phase);
    int n;
    n = 0;
    @(negedge core_clk);
    while (!(wr_phase ? wr_done_o : rd_done_o) && n < TIMEOUT) begin
      n++;
      @(negedge core_clk);
    end
    if (!(wr_phase ? wr_done_o : rd_done_o)) begin
      timed_out(wr_phase ? "wr_done_o" : "rd_done_o");
    end
  endtask

  // second beat carries decoy qp/psn
  task automatic send_wqe(input qp_num_t qp, input psn_t psn);
    int delay;
    delay = 1 + int'($unsigned($random(seed)) % 8);
    repeat (delay) @(posedge core_clk);
    #1;
    wqe_tdata_i  = wqe_beat(qp, psn, 8'h5a);
    wqe_tvalid_i = 1'b1;
    wqe_tlast_i  = 1'b0;
    @(posedge core_clk);
    #1;
    wqe_tdata_i = wqe_beat(~qp, ~psn, 8'ha5);
    wqe_tlast_i = 1'b1;
    @(posedge core_clk);
    #1;
    wqe_tdata_i  = '0;
    wqe_tvalid_i = 1'b0;
    wqe_tlast_i  = 1'b0;
  endtask

  // sampled at negedge and accepted at the next rising edge
  task automatic collect_pkt(input int nbeats);
    int b;
    int n;
    b = 0;
    n = 0;
    while (b < nbeats && n < TIMEOUT) begin
      @(negedge core_clk);
      if (tx_tvalid_o && tx_tready_i) begin
        beat_data[b] = tx_tdata_o;
        beat_keep[b] = tx_tkeep_o;
        beat_last[b] = tx_tlast_o;
        b++;
        n = 0;
      end else begin
        n++;
      end
    end
    if (b < nbeats) begin
      timed_out("a tx beat");
    end
  endtask

  task automatic check_pkt(input int p, input resp_kind_e kind, input roce_hdr_t hdr,
                           input logic [7:0] fill);
    int         total;
    int         nb;
    int         g;
    axis_data_t ed;
    axis_keep_t ek;
    string      tag;
    total = pkt_bytes(kind);
    nb = (total + `AXIS_BYTES - 1) / `AXIS_BYTES;
    tag = $sformatf("pkt %0d", p);
    check_hdr({tag, " header"}, hdr, beat_data[0][`HDR_BYTES*8-1:0]);
    for (int b = 0; b < nb; b++) begin
      for (int l = 0; l < `AXIS_BYTES; l++) begin
        g = b*`AXIS_BYTES + l;
        ek[l] = (g < total);
        if (g >= total) begin
          ed[l*8 +: 8] = 8'h00;
        end else if (g < `HDR_BYTES) begin
          ed[l*8 +: 8] = hdr[g*8 +: 8];
        end else begin
          ed[l*8 +: 8] = fill;
        end
      end
      check_beat($sformatf("%s beat %0d", tag, b), ed, ek, beat_data[b], beat_keep[b]);
      check_flag($sformatf("%s beat %0d tlast", tag, b), b == nb - 1, beat_last[b]);
    end
  endtask

  initial begin : tready_drive
    logic [31:0] rnd;
    tx_tready_i = 1'b0;
    forever begin
      @(posedge core_clk);
      #1;
      rnd = $random(seed);
      tx_tready_i = rnd[0];
    end
  end

  initial begin : post_monitor
    forever begin
      @(negedge core_clk);
      if (post_rd_wqe_o) rd_posts++;
      if (post_wr_wqe_o) wr_posts++;
    end
  end

  initial begin : main_flow
    resp_kind_e  kind;
    qp_num_t     qp;
    psn_t        psn;
    logic [15:0] csum;
    logic        is_rd;
    int          base;
    int          idx;
    core_aresetn = 1'b0;
    conf_done_i  = 1'b0;
    wqe_tdata_i  = '0;
    wqe_tvalid_i = 1'b0;
    wqe_tlast_i  = 1'b0;
    $readmemh("verif/roce_resp_stim.txt", stim);
    src_mac_i     = stim[0];
    src_ip_i      = stim[1][31:0];
    qp3_dst_mac_i = stim[2];
    qp3_dst_ip_i  = stim[3][31:0];
    qp4_dst_mac_i = stim[4];
    qp4_dst_ip_i  = stim[5][31:0];
    repeat (8) @(posedge core_clk);
    #1;
    core_aresetn = 1'b1;

    repeat (20) begin
      @(negedge core_clk);
      check_flag("post_rd before conf_done", 1'b0, post_rd_wqe_o);
      check_flag("post_wr before conf_done", 1'b0, post_wr_wqe_o);
      check_flag("tvalid before conf_done", 1'b0, tx_tvalid_o);
      check_flag("rd_done before conf_done", 1'b0, rd_done_o);
      check_flag("wr_done before conf_done", 1'b0, wr_done_o);
    end
    @(posedge core_clk);
    #1;
    conf_done_i = 1'b1;

    for (int p = 0; p < NUM_PKT; p++) begin
      base = 6 + 4*p;
      kind = resp_kind_e'(stim[base][0]);
      qp   = stim[base + 1][23:0];
      psn  = stim[base + 2][23:0];
      csum = stim[base + 3][15:0];
      idx  = (p < NUM_RD) ? p : p - NUM_RD;
      wait_post(is_rd);
      if (timeout_cnt != 0) begin
        break;
      end
      check_flag($sformatf("pkt %0d post kind", p), kind == RD_RESP, is_rd);
      check_flag($sformatf("pkt %0d rd_done at post", p), p >= NUM_RD, rd_done_o);
      check_flag($sformatf("pkt %0d wr_done at post", p), 1'b0, wr_done_o);
      @(negedge core_clk);
      check_flag($sformatf("pkt %0d post width", p), 1'b0, post_rd_wqe_o | post_wr_wqe_o);
      send_wqe(qp, psn);
      collect_pkt((pkt_bytes(kind) + `AXIS_BYTES - 1) / `AXIS_BYTES);
      if (timeout_cnt != 0) begin
        break;
      end
      check_pkt(p, kind, expected_hdr(kind, qp, psn, csum), 8'h10 + {4'h0, 4'(idx + 1)});
      if (p == NUM_RD - 1) begin
        wait_done(1'b0);
        if (timeout_cnt != 0) begin
          break;
        end
        check_count("read posts at rd_done", NUM_RD, rd_posts);
        check_count("write posts at rd_done", 0, wr_posts);
      end
    end
    if (timeout_cnt == 0) begin
      wait_done(1'b1);
      check_flag("rd_done held", 1'b1, rd_done_o);
      repeat (40) @(negedge core_clk);  // no stray posts afterwards
      check_count("read posts", `NUM_RD_PKT, rd_posts);
      check_count("write posts", `NUM_WR_PKT, wr_posts);
      check_flag("tvalid idle at end", 1'b0, tx_tvalid_o);
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: roce_resp_gen_top.f
+incdir+hdl
hdl/roce_resp_pkg.sv
hdl/tx_job_if.sv
hdl/wqe_req_capture.sv
hdl/resp_seq_ctrl.sv
hdl/roce_hdr_builder.sv
hdl/axis_beat_serializer.sv
hdl/roce_resp_gen_top.sv
verif/roce_resp_gen_chk.sv
verif/tb_roce_resp_gen.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module tb_roce_resp_gen -f roce_resp_gen_top.f &&
./obj_dir/Vtb_roce_resp_gen +verilator+error+limit+100 | tee /dev/stderr |
  grep "ALL CHECKS PASSED" > /dev/null &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }

// File: verif/roce_resp_stim.txt
// config: src mac, src ip, qp3 mac, qp3 ip, qp4 mac, qp4 ip
// per request: kind (0 read resp, 1 ack), qp, psn, expected ipv4 checksum
02aabbcc0001 c0a80001
02aabbcc0003 c0a80003
02aabbcc0004 c0a80004
// read phase
0 000003 000100 e85a
0 000004 000200 e859
0 000007 abcdef e85a
0 000012 123456 e85a
// write phase
1 000004 000300 e959
1 000003 000301 e95a
1 000009 fff000 e95a
1 000004 00fffe e959
